//--- rtl/roadf_pkg.sv
// Road Fighter game constants
package roadf_pkg;

    // Horizontal frame geometry, in pixels
    localparam int H_TOTAL  = 384;
    localparam int H_ACTIVE = 256;
    localparam int HS_START = 272;
    localparam int HS_LEN   = 32;

    // Vertical frame geometry, in lines
    localparam int V_TOTAL  = 264;
    localparam int V_ACTIVE = 224;
    localparam int VS_START = 232;
    localparam int VS_LEN   = 4;

    // Download and SDRAM byte address width
    localparam int DL_AW = 22;

    // Download regions
    // Scroll tiles first, then objects, PCM samples and the palette PROM last
    localparam logic [DL_AW-1:0] SCR_START  = 22'h00_8000;
    localparam logic [DL_AW-1:0] OBJ_START  = 22'h01_0000;
    localparam logic [DL_AW-1:0] PCM_START  = 22'h01_8000;
    localparam logic [DL_AW-1:0] PROM_START = 22'h02_0000;

    // Palette PROM, two bytes per colour entry
    localparam int PROM_LEN = 64;
    localparam int PROM_AW  = $clog2(PROM_LEN);

    // Scroll ROM word address is line (8 bits) then group (5 bits)
    localparam int SCR_AW = 13;

    // One scroll word holds eight 4-bit pixels
    localparam int SCR_DW = 32;

    // 8-pixel groups in the visible part of a line
    localparam int GROUPS = 32;

endpackage

//--- rtl/roadf_clocks.sv
// Pixel clock enables
module roadf_clocks (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    // Free-running divider shared by both enables
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= 3'd0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    // Decoded one count early so the enables come out of flops
    // pxl_cen lands on every second pxl2_cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            pxl2_cen <= cnt[1:0] == 2'b10;
            pxl_cen  <= cnt == 3'b110;
        end
    end

endmodule

//--- rtl/roadf_prog.sv
// ROM download post-processing
module roadf_prog (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [roadf_pkg::DL_AW-1:0]   ioctl_addr,
    input  logic [7:0]                    prog_data,
    input  logic                          prog_we,
    output logic [roadf_pkg::DL_AW-1:0]   post_addr,
    output logic [7:0]                    post_data,
    output logic                          post_we,
    output logic                          prom_we,
    output logic [roadf_pkg::PROM_AW-1:0] prom_addr,
    output logic [7:0]                    prom_data,
    output logic                          is_hyper
);
    import roadf_pkg::*;

    logic             is_scr;
    logic             is_obj;
    logic             is_prom;
    logic [DL_AW-1:0] prom_off;

    assign is_scr  = ioctl_addr >= SCR_START && ioctl_addr < OBJ_START;
    assign is_obj  = ioctl_addr >= OBJ_START && ioctl_addr < PCM_START;
    assign is_prom = ioctl_addr >= PROM_START;

    // Tile bytes are stored so the graphics fetch gets whole pixel rows
    always_comb begin
        post_addr = ioctl_addr;
        if (is_scr) begin
            post_addr[3:0] = {ioctl_addr[2:0], ~ioctl_addr[3]};
        end else if (is_obj) begin
            post_addr[4:0] = {ioctl_addr[2:0], ~ioctl_addr[4], ~ioctl_addr[3]};
        end
    end

    assign post_data = prog_data;
    assign post_we   = prog_we & ~is_prom;

    // PROM bytes go to the on-chip palette, never to SDRAM
    assign prom_off  = ioctl_addr - PROM_START;
    assign prom_we   = prog_we & is_prom;
    assign prom_addr = prom_off[PROM_AW-1:0];
    assign prom_data = prog_data;

    // Hyper Sports boards carry 0xFF in the second PROM byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_hyper <= 1'b0;
        end else if (prog_we && ioctl_addr == PROM_START + DL_AW'(1)) begin
            is_hyper <= &prog_data;
        end
    end

endmodule

//--- rtl/roadf_vtimer.sv
// Video timing generator
module roadf_vtimer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    output logic [8:0] hdump,
    output logic [8:0] vdump,
    output logic       LHBL,
    output logic       LVBL,
    output logic       HS,
    output logic       VS
);
    import roadf_pkg::*;

    logic h_last;
    logic v_last;

    assign h_last = hdump == 9'(H_TOTAL - 1);
    assign v_last = vdump == 9'(V_TOTAL - 1);

    // Pixel and line counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= 9'd0;
            vdump <= 9'd0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hdump <= 9'd0;
                if (v_last) begin
                    vdump <= 9'd0;
                end else begin
                    vdump <= vdump + 9'd1;
                end
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end

    // Blanking and syncs sampled one pxl_cen after the counters,
    // in step with the registered colour from the scroll layer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            LHBL <= 1'b0;
            LVBL <= 1'b0;
            HS   <= 1'b0;
            VS   <= 1'b0;
        end else if (pxl_cen) begin
            LHBL <= hdump < 9'(H_ACTIVE);
            LVBL <= vdump < 9'(V_ACTIVE);
            HS   <= hdump >= 9'(HS_START) && hdump < 9'(HS_START + HS_LEN);
            VS   <= vdump >= 9'(VS_START) && vdump < 9'(VS_START + VS_LEN);
        end
    end

endmodule

//--- rtl/roadf_scroll.sv
// Scroll layer
module roadf_scroll (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic                          dwn_busy,
    input  logic                          is_hyper,
    input  logic [8:0]                    hdump,
    input  logic [8:0]                    vdump,
    input  logic                          prom_we,
    input  logic [roadf_pkg::PROM_AW-1:0] prom_addr,
    input  logic [7:0]                    prom_data,
    output logic                          scr_cs,
    output logic [roadf_pkg::SCR_AW-1:0]  scr_addr,
    input  logic [roadf_pkg::SCR_DW-1:0]  scr_data,
    input  logic                          scr_ok,
    output logic [3:0]                    red,
    output logic [3:0]                    green,
    output logic [3:0]                    blue
);
    import roadf_pkg::*;

    logic [5:0]         grp;
    logic [8:0]         v_next;
    logic               req_go;
    logic [SCR_AW-1:0]  req_addr;
    logic               load;
    logic               stale;
    logic               word_valid;
    logic [SCR_DW-1:0]  word;
    logic [SCR_DW-1:0]  shifter;
    logic [PROM_AW-2:0] pal_idx;
    logic [7:0]         pal_lo;
    logic [7:0]         pal_hi;
    logic               active;
    logic [7:0]         prom_mem [PROM_LEN];

    assign grp    = hdump[8:3];
    assign v_next = (vdump == 9'(V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;

    // Next group is requested at the start of the current one
    // Group 0 of the next line goes out as blanking begins
    always_comb begin
        req_go   = 1'b0;
        req_addr = {vdump[7:0], grp[4:0] + 5'd1};
        if (hdump == 9'(H_ACTIVE)) begin
            req_go   = 1'b1;
            req_addr = {v_next[7:0], 5'd0};
        end else if (hdump[2:0] == 3'd0 && grp < 6'(GROUPS - 1)) begin
            req_go = 1'b1;
        end
        req_go = req_go & pxl_cen & ~dwn_busy & ~scr_cs;
    end

    // Group boundaries that lead into a visible group
    assign load = pxl_cen &&
                  ((hdump[2:0] == 3'd7 && grp < 6'(GROUPS - 1)) ||
                   hdump == 9'(H_TOTAL - 1));

    // Fetch FSM, scr_cs doubles as the waiting state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scr_cs     <= 1'b0;
            stale      <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (load) begin
                word_valid <= 1'b0;
                // Group started without its word, drop it when it comes
                if (scr_cs && !scr_ok) begin
                    stale <= 1'b1;
                end
            end
            if (scr_cs && scr_ok) begin
                scr_cs <= 1'b0;
                stale  <= 1'b0;
                if (!stale && !load) begin
                    word_valid <= 1'b1;
                end
            end else if (req_go) begin
                scr_cs <= 1'b1;
            end
        end
    end

    // Address only moves while no request is open
    always_ff @(posedge clk) begin
        if (req_go) begin
            scr_addr <= req_addr;
        end
        if (scr_cs && scr_ok && !stale) begin
            word <= scr_data;
        end
    end

    // Pixel shifter, lowest nibble is the pixel on screen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shifter <= '0;
        end else if (load) begin
            shifter <= word_valid ? word : '0;
        end else if (pxl_cen) begin
            shifter <= shifter >> 4;
        end
    end

    // Palette PROM filled by the download
    always_ff @(posedge clk) begin
        if (prom_we) begin
            prom_mem[prom_addr] <= prom_data;
        end
    end

    assign pal_idx = {is_hyper, shifter[3:0]};
    assign pal_lo  = prom_mem[{pal_idx, 1'b0}];
    assign pal_hi  = prom_mem[{pal_idx, 1'b1}];
    assign active  = hdump < 9'(H_ACTIVE) && vdump < 9'(V_ACTIVE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red   <= 4'd0;
            green <= 4'd0;
            blue  <= 4'd0;
        end else if (dwn_busy) begin
            red   <= 4'd0;
            green <= 4'd0;
            blue  <= 4'd0;
        end else if (pxl_cen) begin
            red   <= active ? pal_lo[3:0] : 4'd0;
            green <= active ? pal_lo[7:4] : 4'd0;
            blue  <= active ? pal_hi[3:0] : 4'd0;
        end
    end

endmodule

//--- rtl/roadf_game.sv
// Road Fighter game top
module roadf_game (
    input  logic                         clk,
    input  logic                         rst_n,
    // ROM download
    input  logic [roadf_pkg::DL_AW-1:0]  ioctl_addr,
    input  logic [7:0]                   prog_data,
    input  logic                         prog_we,
    input  logic                         dwn_busy,
    // SDRAM loader
    output logic [roadf_pkg::DL_AW-1:0]  post_addr,
    output logic [7:0]                   post_data,
    output logic                         post_we,
    // Scroll ROM
    output logic                         scr_cs,
    output logic [roadf_pkg::SCR_AW-1:0] scr_addr,
    input  logic [roadf_pkg::SCR_DW-1:0] scr_data,
    input  logic                         scr_ok,
    // Video
    output logic                         pxl2_cen,
    output logic                         pxl_cen,
    output logic [3:0]                   red,
    output logic [3:0]                   green,
    output logic [3:0]                   blue,
    output logic                         LHBL,
    output logic                         LVBL,
    output logic                         HS,
    output logic                         VS
);
    import roadf_pkg::*;

    logic [8:0]         hdump;
    logic [8:0]         vdump;
    logic               prom_we;
    logic [PROM_AW-1:0] prom_addr;
    logic [7:0]         prom_data;
    logic               is_hyper;

    roadf_clocks u_clocks (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen)
    );

    roadf_prog u_prog (
        .clk        (clk),
        .rst_n      (rst_n),
        .ioctl_addr (ioctl_addr),
        .prog_data  (prog_data),
        .prog_we    (prog_we),
        .post_addr  (post_addr),
        .post_data  (post_data),
        .post_we    (post_we),
        .prom_we    (prom_we),
        .prom_addr  (prom_addr),
        .prom_data  (prom_data),
        .is_hyper   (is_hyper)
    );

    roadf_vtimer u_vtimer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .LHBL    (LHBL),
        .LVBL    (LVBL),
        .HS      (HS),
        .VS      (VS)
    );

    roadf_scroll u_scroll (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .dwn_busy  (dwn_busy),
        .is_hyper  (is_hyper),
        .hdump     (hdump),
        .vdump     (vdump),
        .prom_we   (prom_we),
        .prom_addr (prom_addr),
        .prom_data (prom_data),
        .scr_cs    (scr_cs),
        .scr_addr  (scr_addr),
        .scr_data  (scr_data),
        .scr_ok    (scr_ok),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

//--- verification/roadf_checker.sv
// Download and video monitor
module roadf_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        check_en,
    input  logic [roadf_pkg::DL_AW-1:0] ioctl_addr,
    input  logic [7:0]                  prog_data,
    input  logic                        prog_we,
    input  logic                        dwn_busy,
    input  logic [roadf_pkg::DL_AW-1:0] post_addr,
    input  logic [7:0]                  post_data,
    input  logic                        post_we,
    input  logic                        scr_cs,
    input  logic                        pxl2_cen,
    input  logic                        pxl_cen,
    input  logic [3:0]                  red,
    input  logic [3:0]                  green,
    input  logic [3:0]                  blue,
    input  logic                        LHBL,
    input  logic                        LVBL,
    input  logic                        HS,
    input  logic                        VS,
    output int                          error_count,
    output int                          pixel_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import roadf_pkg::*;

    logic [7:0] prom_model [PROM_LEN];
    logic       hyper_model;
    int         busy_cnt;
    int         hcnt;
    int         lcnt;
    int         p2_gap;
    int         p1_gap;
    logic       p2_seen;
    logic       p1_seen;
    logic       h_seen;
    logic       v_seen;
    logic       prev_lhbl;
    logic       prev_lvbl;
    logic       prev_hs;
    logic       prev_vs;

    initial begin
        error_count = 0;
        pixel_count = 0;
        hyper_model = 1'b0;
        foreach (prom_model[i]) prom_model[i] = 8'd0;
    end

    function automatic logic [31:0] rom_word(input logic [SCR_AW-1:0] a);
        return {a, 3'b101, a ^ 13'h1a5b, 3'b011};
    endfunction

    function automatic logic [DL_AW-1:0] expected_post_addr(input logic [DL_AW-1:0] a);
        logic [DL_AW-1:0] r;
        r = a;
        if (a >= SCR_START && a < OBJ_START) begin
            r[3:0] = {a[2], a[1], a[0], ~a[3]};
        end else if (a >= OBJ_START && a < PCM_START) begin
            r[4:0] = {a[2], a[1], a[0], ~a[4], ~a[3]};
        end
        return r;
    endfunction

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
        error_count++;
    endtask

    // pxl2_cen every 4 clk, pxl_cen every 8 clk and always on a pxl2_cen
    task automatic check_enables();
        p2_gap++;
        p1_gap++;
        if (pxl2_cen || p2_gap > 4) begin
            if (p2_seen && p2_gap != 4) report("pxl2_cen_period", 4, p2_gap);
            p2_gap  = 0;
            p2_seen = 1'b1;
        end
        if (pxl_cen && !pxl2_cen) report("pxl_cen_align", 1, pxl2_cen);
        if (pxl_cen || p1_gap > 8) begin
            if (p1_seen && p1_gap != 8) report("pxl_cen_period", 8, p1_gap);
            p1_gap  = 0;
            p1_seen = 1'b1;
        end
    endtask

    // Pixel n of line m from the hashed ROM word and the model palette
    task automatic check_pixel(input int m, input int n);
        logic [SCR_AW-1:0] a;
        logic [31:0]       w;
        logic [4:0]        idx;
        logic [7:0]        lo;
        logic [7:0]        hi;
        a   = {8'(m), 5'(n / 8)};
        w   = rom_word(a);
        idx = {hyper_model, 4'(w >> (4 * (n % 8)))};
        lo  = prom_model[2 * idx];
        hi  = prom_model[2 * idx + 1];
        if ({red, green, blue} !== {lo[3:0], lo[7:4], hi[3:0]}) begin
            report("pixel_rgb", {lo[3:0], lo[7:4], hi[3:0]}, {red, green, blue});
        end
        pixel_count++;
    endtask

    task automatic sample_video();
        hcnt++;
        if (LHBL && !prev_lhbl) begin
            if (h_seen && hcnt != H_TOTAL) report("line_period", H_TOTAL, hcnt);
            hcnt   = 0;
            h_seen = 1'b1;
            lcnt++;
        end
        if (!LHBL && prev_lhbl && h_seen && hcnt != H_ACTIVE) begin
            report("line_active", H_ACTIVE, hcnt);
        end
        if (HS && !prev_hs && h_seen && hcnt != HS_START) report("hsync_start", HS_START, hcnt);
        if (!HS && prev_hs && h_seen && hcnt != HS_START + HS_LEN) begin
            report("hsync_end", HS_START + HS_LEN, hcnt);
        end
        if (LVBL && !prev_lvbl) begin
            if (v_seen && lcnt != V_TOTAL) report("frame_period", V_TOTAL, lcnt);
            lcnt   = 0;
            v_seen = 1'b1;
        end
        if (!LVBL && prev_lvbl && v_seen && lcnt != V_ACTIVE) begin
            report("frame_active", V_ACTIVE, lcnt);
        end
        if (VS && !prev_vs && v_seen && lcnt != VS_START) report("vsync_start", VS_START, lcnt);
        if (!VS && prev_vs && v_seen && lcnt != VS_START + VS_LEN) begin
            report("vsync_end", VS_START + VS_LEN, lcnt);
        end
        if (LHBL && LVBL && check_en) check_pixel(lcnt, hcnt);
        prev_lhbl = LHBL;
        prev_lvbl = LVBL;
        prev_hs   = HS;
        prev_vs   = VS;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt  = 0;
            hcnt      = 0;
            lcnt      = 0;
            p2_gap    = 0;
            p1_gap    = 0;
            p2_seen   = 1'b0;
            p1_seen   = 1'b0;
            h_seen    = 1'b0;
            v_seen    = 1'b0;
            prev_lhbl = 1'b0;
            prev_lvbl = 1'b0;
            prev_hs   = 1'b0;
            prev_vs   = 1'b0;
        end else begin
            if (post_addr !== expected_post_addr(ioctl_addr)) begin
                report("download_addr", expected_post_addr(ioctl_addr), post_addr);
            end
            if (post_data !== prog_data) report("download_data", prog_data, post_data);
            if (post_we !== (prog_we && ioctl_addr < PROM_START)) begin
                report("download_we", prog_we && ioctl_addr < PROM_START, post_we);
            end
            if (prog_we && ioctl_addr >= PROM_START && ioctl_addr < PROM_START + PROM_LEN) begin
                prom_model[ioctl_addr - PROM_START] = prog_data;
            end
            if (prog_we && ioctl_addr == PROM_START + 1) hyper_model = &prog_data;
            busy_cnt = dwn_busy ? busy_cnt + 1 : 0;
            if (busy_cnt >= 2 && {red, green, blue} !== 12'd0) begin
                report("download_blank", 0, {red, green, blue});
            end
            // An open fetch finishes well inside 48 cycles
            if (busy_cnt > 48 && scr_cs !== 1'b0) report("download_no_fetch", 0, scr_cs);
            check_enables();
            if (pxl_cen) sample_video();
        end
    end

endmodule

//--- verification/roadf_game_sva.sv
// Scroll ROM handshake assertions
module roadf_game_sva (
    input logic clk,
    input logic rst_n,
    input logic dwn_busy,
    input logic scr_cs,
    input logic scr_ok,
    input logic [roadf_pkg::SCR_AW-1:0] scr_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        scr_cs && !scr_ok |=> $stable(scr_addr))
        else begin
            $error("scr_addr moved during an open request");
            fail_count++;
        end

    a_cs_drop: assert property (@(posedge clk) disable iff (!rst_n)
        scr_cs && scr_ok |=> !scr_cs)
        else begin
            $error("scr_cs still high after scr_ok");
            fail_count++;
        end

    a_no_fetch_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !scr_cs && dwn_busy |=> !scr_cs)
        else begin
            $error("request started during download");
            fail_count++;
        end

    a_reset_cs: assert property (@(posedge clk) !rst_n |-> !scr_cs)
        else begin
            $error("scr_cs high in reset");
            fail_count++;
        end

endmodule

bind roadf_scroll roadf_game_sva sva0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .dwn_busy (dwn_busy),
    .scr_cs   (scr_cs),
    .scr_ok   (scr_ok),
    .scr_addr (scr_addr)
);

//--- verification/roadf_game_tb.sv
// Road Fighter game testbench
module roadf_game_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import roadf_pkg::*;

    localparam int     N_RANDOM  = 300;
    localparam int     ROM_MAXLAT = 40;
    localparam longint FRAME_CLK = H_TOTAL * V_TOTAL * 8;
    localparam longint DL_CLK    = (N_RANDOM + 2 * PROM_LEN) * 2 + 16;
    localparam longint TIMEOUT_NS = (DL_CLK + 3 * FRAME_CLK) * 10 * 11 / 10;

    logic               clk;
    logic               rst_n;
    logic [DL_AW-1:0]   ioctl_addr;
    logic [7:0]         prog_data;
    logic               prog_we;
    logic               dwn_busy;
    logic [DL_AW-1:0]   post_addr;
    logic [7:0]         post_data;
    logic               post_we;
    logic               scr_cs;
    logic [SCR_AW-1:0]  scr_addr;
    logic [SCR_DW-1:0]  scr_data;
    logic               scr_ok;
    logic               pxl2_cen;
    logic               pxl_cen;
    logic [3:0]         red;
    logic [3:0]         green;
    logic [3:0]         blue;
    logic               LHBL;
    logic               LVBL;
    logic               HS;
    logic               VS;
    logic               check_en;
    int                 chk_errors;
    int                 pixel_count;
    int                 tb_errors;
    int                 lat;

    roadf_game dut0 (.*);

    roadf_checker chk0 (.*, .error_count(chk_errors));

    // Same fixed hash the checker expects
    function automatic logic [31:0] rom_word(input logic [SCR_AW-1:0] a);
        return {a, 3'b101, a ^ 13'h1a5b, 3'b011};
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Scroll ROM with random latency
    initial begin
        forever begin
            @(posedge clk);
            if (scr_cs && rst_n) begin
                lat = 1 + $urandom % ROM_MAXLAT;
                repeat (lat - 1) @(posedge clk);
                #1;
                scr_data = rom_word(scr_addr);
                scr_ok   = 1'b1;
                @(posedge clk);
                #1;
                scr_ok = 1'b0;
            end
        end
    end

    task automatic write_byte(input logic [DL_AW-1:0] a, input logic [7:0] d);
        ioctl_addr = a;
        prog_data  = d;
        prog_we    = 1'b1;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // Region picked first, then an address inside it
    task automatic random_writes(input int count);
        int unsigned bounds [6];
        int unsigned r;
        int unsigned lo;
        bounds = '{0, SCR_START, OBJ_START, PCM_START, PROM_START, PROM_START + PROM_LEN};
        for (int i = 0; i < count; i++) begin
            r  = $urandom % 5;
            lo = bounds[r];
            write_byte(DL_AW'(lo + $urandom % (bounds[r + 1] - lo)), 8'($urandom));
        end
    endtask

    // Second byte selects the board variant
    task automatic load_prom(input logic hyper);
        logic [7:0] d;
        for (int i = 0; i < PROM_LEN; i++) begin
            d = 8'($urandom);
            if (i == 1) begin
                d = hyper ? 8'hff : ((d == 8'hff) ? 8'h7f : d);
            end
            write_byte(PROM_START + DL_AW'(i), d);
        end
    endtask

    task automatic check_frame();
        @(posedge LVBL);
        #1;
        check_en = 1'b1;
        @(negedge LVBL);
        #1;
        check_en = 1'b0;
    endtask

    task automatic expect_low(input string name, input logic [31:0] actual);
        if (actual !== 0) begin
            $display("ERROR %s: expected 0, actual %0h", name, actual);
            tb_errors++;
        end
    endtask

    initial begin
        void'($urandom(32'hcaf2_8568));
        tb_errors  = 0;
        rst_n      = 1'b0;
        ioctl_addr = '0;
        prog_data  = 8'd0;
        prog_we    = 1'b0;
        dwn_busy   = 1'b1;
        scr_ok     = 1'b0;
        scr_data   = '0;
        check_en   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        expect_low("reset_scr_cs", 32'(scr_cs));
        expect_low("reset_post_we", 32'(post_we));
        expect_low("reset_sync", 32'({LHBL, LVBL, HS, VS}));
        expect_low("reset_rgb", 32'({red, green, blue}));
        rst_n = 1'b1;

        random_writes(N_RANDOM);
        load_prom(1'b0);
        dwn_busy = 1'b0;
        check_frame();

        // Reload during vertical blanking
        dwn_busy = 1'b1;
        load_prom(1'b1);
        dwn_busy = 1'b0;
        check_frame();

        if (pixel_count != 2 * H_ACTIVE * V_ACTIVE) begin
            $display("Pixel check covered %0d pixels instead of %0d",
                     pixel_count, 2 * H_ACTIVE * V_ACTIVE);
            tb_errors++;
        end
        $display("Errors: checker %0d, testbench %0d, assertions %0d",
                 chk_errors, tb_errors, dut0.u_scroll.sva0.fail_count);
        if (chk_errors == 0 && tb_errors == 0 && dut0.u_scroll.sva0.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- verilog.f
rtl/roadf_pkg.sv
rtl/roadf_clocks.sv
rtl/roadf_prog.sv
rtl/roadf_vtimer.sv
rtl/roadf_scroll.sv
rtl/roadf_game.sv
verification/roadf_checker.sv
verification/roadf_game_sva.sv
verification/roadf_game_tb.sv

//--- Bender.yml
package:
  name: roadf_game

sources:
  - rtl/roadf_pkg.sv
  - rtl/roadf_clocks.sv
  - rtl/roadf_prog.sv
  - rtl/roadf_vtimer.sv
  - rtl/roadf_scroll.sv
  - rtl/roadf_game.sv
  - target: test
    files:
      - verification/roadf_checker.sv
      - verification/roadf_game_sva.sv
      - verification/roadf_game_tb.sv
